// ==== src/tl_pkg.sv ====
package tl_pkg;

    typedef logic [2:0] opcode_t;
    typedef logic [2:0] grow_t;
    typedef logic [1:0] cap_t;

    // Channel A
    localparam opcode_t ACQUIRE_BLOCK = 3'd6;
    localparam opcode_t ACQUIRE_PERM  = 3'd7;

    // Channel B
    localparam opcode_t PROBE_BLOCK   = 3'd6;

    // Channel C
    localparam opcode_t PROBE_ACK     = 3'd4;
    localparam opcode_t RELEASE       = 3'd6;

    // Channel D
    localparam opcode_t GRANT         = 3'd4;
    localparam opcode_t RELEASE_ACK   = 3'd6;

    // Grow param of an Acquire
    localparam grow_t NTOB = 3'd0;
    localparam grow_t NTOT = 3'd1;

    // Cap param of probes and grants
    localparam cap_t TO_T = 2'd0;
    localparam cap_t TO_B = 2'd1;
    localparam cap_t TO_N = 2'd2;

    localparam int SOURCE_W = 6;
    localparam int CID_W    = 2;   // Core id in the top source bits

endpackage

// ==== src/l2_dir_pkg.sv ====
package l2_dir_pkg;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 6;    // 64-byte lines

    // Default geometry
    localparam int DIR_CORES = 4;
    localparam int DIR_WAYS  = 4;
    localparam int DIR_SETS  = 16;

    localparam int TAG_W = ADDR_W - OFFSET_W - $clog2(DIR_SETS);

    typedef struct packed {
        logic                     valid;
        logic [TAG_W-1:0]         tag;
        logic [DIR_CORES-1:0]     sharers;
        logic                     owner_valid;
        logic [tl_pkg::CID_W-1:0] owner;
    } dir_entry_t;

    // Acquire as queued from channel A
    typedef struct packed {
        tl_pkg::opcode_t             opcode;
        tl_pkg::grow_t               grow;
        logic [tl_pkg::SOURCE_W-1:0] source;
        logic [ADDR_W-1:0]           address;
    } acq_req_t;

    // Dataless Release from channel C
    typedef struct packed {
        logic [tl_pkg::SOURCE_W-1:0] source;
        logic [ADDR_W-1:0]           address;
    } rel_req_t;

endpackage

// ==== src/req_fifo.sv ====
`timescale 1ns/1ns

module req_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_valid_i,
    output logic     push_ready_o,
    input  payload_t push_data_i,
    output logic     pop_valid_o,
    input  logic     pop_ready_i,
    output payload_t pop_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    assign push_ready_o = (count_q != (PTR_W+1)'(DEPTH));   // Drops when full
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

// ==== src/dir_store.sv ====
`timescale 1ns/1ns

module dir_store #(
    parameter int CORES = 4,
    parameter int WAYS  = 4,
    parameter int SETS  = 16
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic [$clog2(SETS)-1:0]           rd_set_i,
    output l2_dir_pkg::dir_entry_t [WAYS-1:0] rd_entries_o,
    output logic [$clog2(WAYS)-1:0]           victim_way_o,
    input  logic                              we_i,
    input  logic [$clog2(SETS)-1:0]           wr_set_i,
    input  logic [$clog2(WAYS)-1:0]           wr_way_i,
    input  l2_dir_pkg::dir_entry_t            wr_entry_i,
    input  logic                              victim_advance_i
);
    import l2_dir_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);

    dir_entry_t [WAYS-1:0] dir_q [SETS];     // Tag and state per way
    logic [WAY_W-1:0]      victim_q [SETS];  // Round-robin pointer per set
    logic [IDX_W-1:0]      rd_set_q;
    logic [CORES-1:0]      wr_holders;
    dir_entry_t            wr_entry;

    // An owner is always counted among the sharers
    always_comb begin
        wr_holders = wr_entry_i.sharers;
        if (wr_entry_i.owner_valid) begin
            wr_holders[wr_entry_i.owner] = 1'b1;
        end
        wr_entry         = wr_entry_i;
        wr_entry.sharers = wr_holders;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_set_q <= '0;
            for (int s = 0; s < SETS; s++) begin
                dir_q[s]    <= '0;   // All ways invalid
                victim_q[s] <= '0;
            end
        end else begin
            rd_set_q <= rd_set_i;
            if (we_i) begin
                dir_q[wr_set_i][wr_way_i] <= wr_entry;
            end
            if (victim_advance_i) begin
                if (victim_q[wr_set_i] == WAY_W'(WAYS - 1)) begin
                    victim_q[wr_set_i] <= '0;
                end else begin
                    victim_q[wr_set_i] <= victim_q[wr_set_i] + 1'b1;
                end
            end
        end
    end

    // Set registered above, so the ways show up one cycle after the request
    assign rd_entries_o = dir_q[rd_set_q];
    assign victim_way_o = victim_q[rd_set_q];

endmodule

// ==== src/probe_tracker.sv ====
`timescale 1ns/1ns

module probe_tracker #(
    parameter int CORES = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          start_i,
    input  logic [CORES-1:0]              mask_i,
    input  logic [l2_dir_pkg::ADDR_W-1:0] addr_i,
    input  tl_pkg::cap_t                  cap_i,
    output logic                          done_o,
    output logic                          b_valid_o,
    input  logic                          b_ready_i,
    output tl_pkg::opcode_t               b_opcode_o,
    output tl_pkg::cap_t                  b_param_o,
    output logic [l2_dir_pkg::ADDR_W-1:0] b_address_o,
    output logic [tl_pkg::CID_W-1:0]      b_dest_o,
    input  logic                          c_valid_i,
    output logic                          c_ready_o,
    input  tl_pkg::opcode_t               c_opcode_i,
    input  logic [tl_pkg::SOURCE_W-1:0]   c_source_i,
    input  logic [l2_dir_pkg::ADDR_W-1:0] c_address_i,
    output logic                          rel_valid_o,
    input  logic                          rel_ready_i,
    output l2_dir_pkg::rel_req_t          rel_data_o
);
    import tl_pkg::*;
    import l2_dir_pkg::*;

    logic              active_q;
    logic [CORES-1:0]  unsent_q;
    logic [CORES-1:0]  pending_q;   // Still waiting for a ProbeAck
    logic [ADDR_W-1:0] addr_q;
    cap_t              cap_q;
    logic              c_is_ack;
    logic              c_is_rel;
    logic [CORES-1:0]  ack_bit;

    // Lowest unsent core goes first
    always_comb begin
        b_dest_o = '0;
        for (int i = CORES - 1; i >= 0; i--) begin
            if (unsent_q[i]) begin
                b_dest_o = CID_W'(i);
            end
        end
    end

    assign b_valid_o   = active_q && (unsent_q != '0);
    assign b_opcode_o  = PROBE_BLOCK;
    assign b_param_o   = cap_q;
    assign b_address_o = addr_q;

    assign done_o = active_q && (unsent_q == '0) && (pending_q == '0);

    assign c_is_ack    = (c_opcode_i == PROBE_ACK);
    assign c_is_rel    = (c_opcode_i == RELEASE);
    assign c_ready_o   = c_is_rel ? rel_ready_i : 1'b1;   // ProbeAcks never stall
    assign rel_valid_o = c_valid_i && c_is_rel;
    assign rel_data_o  = '{source: c_source_i, address: c_address_i};
    assign ack_bit     = (c_valid_i && c_is_ack) ?
                         CORES'(1) << c_source_i[SOURCE_W-1 -: CID_W] : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q  <= 1'b0;
            unsent_q  <= '0;
            pending_q <= '0;
        end else if (start_i) begin
            active_q  <= 1'b1;
            unsent_q  <= mask_i;
            pending_q <= mask_i;
        end else begin
            if (b_valid_o && b_ready_i) begin
                unsent_q[b_dest_o] <= 1'b0;
            end
            pending_q <= pending_q & ~ack_bit;
            if (done_o) begin
                active_q <= 1'b0;   // One-cycle done
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            addr_q <= addr_i;
            cap_q  <= cap_i;
        end
    end

endmodule

// ==== src/coherence_ctrl.sv ====
`timescale 1ns/1ns

module coherence_ctrl #(
    parameter int CORES = 4,
    parameter int WAYS  = 4,
    parameter int SETS  = 16
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              acq_valid_i,
    output logic                              acq_ready_o,
    input  l2_dir_pkg::acq_req_t              acq_data_i,
    input  logic                              rel_valid_i,
    output logic                              rel_ready_o,
    input  l2_dir_pkg::rel_req_t              rel_data_i,
    output logic [$clog2(SETS)-1:0]           rd_set_o,
    input  l2_dir_pkg::dir_entry_t [WAYS-1:0] rd_entries_i,
    input  logic [$clog2(WAYS)-1:0]           victim_way_i,
    output logic                              we_o,
    output logic [$clog2(SETS)-1:0]           wr_set_o,
    output logic [$clog2(WAYS)-1:0]           wr_way_o,
    output l2_dir_pkg::dir_entry_t            wr_entry_o,
    output logic                              victim_advance_o,
    output logic                              probe_start_o,
    output logic [CORES-1:0]                  probe_mask_o,
    output logic [l2_dir_pkg::ADDR_W-1:0]     probe_addr_o,
    output tl_pkg::cap_t                      probe_cap_o,
    input  logic                              probe_done_i,
    output logic                              d_valid_o,
    input  logic                              d_ready_i,
    output tl_pkg::opcode_t                   d_opcode_o,
    output tl_pkg::cap_t                      d_param_o,
    output logic [tl_pkg::SOURCE_W-1:0]       d_source_o
);
    import tl_pkg::*;
    import l2_dir_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);

    typedef enum logic [2:0] {
        ST_IDLE, ST_READ, ST_CHECK, ST_PROBE_WAIT, ST_UPDATE, ST_RESP
    } state_t;

    state_t              state_q;
    state_t              state_d;
    logic                is_rel_q;
    logic                want_t_q;    // AcquirePerm or NtoT
    logic [SOURCE_W-1:0] source_q;
    logic [ADDR_W-1:0]   addr_q;
    logic [CID_W-1:0]    req_core;
    logic [CORES-1:0]    req_bit;
    logic [TAG_W-1:0]    req_tag;
    logic [IDX_W-1:0]    req_idx;
    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    dir_entry_t          hit_entry;
    dir_entry_t          victim_entry;
    dir_entry_t          new_entry;
    logic [WAY_W-1:0]    way_q;
    dir_entry_t          entry_q;
    logic                write_q;
    logic                advance_q;

    function automatic logic [CORES-1:0] holders(dir_entry_t e);
        logic [CORES-1:0] h;
        h = e.sharers;
        if (e.owner_valid) begin
            h[e.owner] = 1'b1;
        end
        return h;
    endfunction

    assign req_core = source_q[SOURCE_W-1 -: CID_W];
    assign req_bit  = CORES'(1) << req_core;
    assign req_tag  = addr_q[ADDR_W-1 -: TAG_W];
    assign req_idx  = addr_q[OFFSET_W +: IDX_W];

    // Tag compare over all ways
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        hit_entry = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (rd_entries_i[w].valid && rd_entries_i[w].tag == req_tag) begin
                hit       = 1'b1;
                hit_way   = WAY_W'(w);
                hit_entry = rd_entries_i[w];
            end
        end
    end

    assign victim_entry = rd_entries_i[victim_way_i];

    // Probe set, cap and the entry to write back
    always_comb begin
        probe_mask_o = '0;
        probe_cap_o  = TO_N;
        probe_addr_o = {addr_q[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
        new_entry    = hit_entry;
        if (is_rel_q) begin
            new_entry.sharers = hit_entry.sharers & ~req_bit;
            if (hit_entry.owner == req_core) begin
                new_entry.owner_valid = 1'b0;
            end
        end else begin
            if (hit && want_t_q) begin
                probe_mask_o = holders(hit_entry) & ~req_bit;
            end else if (hit && hit_entry.owner_valid && hit_entry.owner != req_core) begin
                probe_mask_o = CORES'(1) << hit_entry.owner;
                probe_cap_o  = TO_B;
            end else if (!hit) begin
                new_entry = '{valid: 1'b1, tag: req_tag, default: '0};
                if (victim_entry.valid) begin   // Eviction round at the victim's line
                    probe_mask_o = holders(victim_entry);
                    probe_addr_o = {victim_entry.tag, req_idx, OFFSET_W'(0)};
                end
            end
            if (want_t_q) begin
                new_entry.sharers     = req_bit;
                new_entry.owner_valid = 1'b1;
                new_entry.owner       = req_core;
            end else begin
                new_entry.sharers     = holders(new_entry) | req_bit;
                new_entry.owner_valid = 1'b0;
            end
        end
    end

    assign acq_ready_o      = (state_q == ST_IDLE) && !rel_valid_i;   // Releases go first
    assign rel_ready_o      = (state_q == ST_IDLE);
    assign rd_set_o         = req_idx;
    assign probe_start_o    = (state_q == ST_CHECK) && (probe_mask_o != '0);
    assign we_o             = (state_q == ST_UPDATE) && write_q;
    assign victim_advance_o = (state_q == ST_UPDATE) && advance_q;
    assign wr_set_o         = req_idx;
    assign wr_way_o         = way_q;
    assign wr_entry_o       = entry_q;
    assign d_valid_o        = (state_q == ST_RESP);
    assign d_opcode_o       = is_rel_q ? RELEASE_ACK : GRANT;
    assign d_param_o        = (is_rel_q || want_t_q) ? TO_T : TO_B;
    assign d_source_o       = source_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (rel_valid_i || acq_valid_i) begin
                    state_d = ST_READ;
                end
            end
            ST_READ:  state_d = ST_CHECK;
            ST_CHECK: state_d = probe_start_o ? ST_PROBE_WAIT : ST_UPDATE;
            ST_PROBE_WAIT: begin
                if (probe_done_i) begin
                    state_d = ST_UPDATE;
                end
            end
            ST_UPDATE: state_d = ST_RESP;
            ST_RESP: begin
                if (d_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= ST_IDLE;
            write_q   <= 1'b0;
            advance_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_CHECK) begin
                write_q   <= hit || !is_rel_q;    // Release miss leaves the directory alone
                advance_q <= !hit && !is_rel_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rel_valid_i && rel_ready_o) begin
            is_rel_q <= 1'b1;
            want_t_q <= 1'b0;
            source_q <= rel_data_i.source;
            addr_q   <= rel_data_i.address;
        end else if (acq_valid_i && acq_ready_o) begin
            is_rel_q <= 1'b0;
            want_t_q <= (acq_data_i.opcode == ACQUIRE_PERM) || (acq_data_i.grow == NTOT);
            source_q <= acq_data_i.source;
            addr_q   <= acq_data_i.address;
        end
        if (state_q == ST_CHECK) begin
            way_q   <= hit ? hit_way : victim_way_i;
            entry_q <= new_entry;
        end
    end

endmodule

// ==== src/l2_dir_top.sv ====
`timescale 1ns/1ns

module l2_dir_top #(
    parameter int CORES = l2_dir_pkg::DIR_CORES,
    parameter int WAYS  = l2_dir_pkg::DIR_WAYS,
    parameter int SETS  = l2_dir_pkg::DIR_SETS
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          a_valid_i,
    output logic                          a_ready_o,
    input  tl_pkg::opcode_t               a_opcode_i,
    input  tl_pkg::grow_t                 a_param_i,
    input  logic [tl_pkg::SOURCE_W-1:0]   a_source_i,
    input  logic [l2_dir_pkg::ADDR_W-1:0] a_address_i,
    output logic                          b_valid_o,
    input  logic                          b_ready_i,
    output tl_pkg::opcode_t               b_opcode_o,
    output tl_pkg::cap_t                  b_param_o,
    output logic [l2_dir_pkg::ADDR_W-1:0] b_address_o,
    output logic [tl_pkg::CID_W-1:0]      b_dest_o,
    input  logic                          c_valid_i,
    output logic                          c_ready_o,
    input  tl_pkg::opcode_t               c_opcode_i,
    input  logic [tl_pkg::SOURCE_W-1:0]   c_source_i,
    input  logic [l2_dir_pkg::ADDR_W-1:0] c_address_i,
    output logic                          d_valid_o,
    input  logic                          d_ready_i,
    output tl_pkg::opcode_t               d_opcode_o,
    output tl_pkg::cap_t                  d_param_o,
    output logic [tl_pkg::SOURCE_W-1:0]   d_source_o
);
    import tl_pkg::*;
    import l2_dir_pkg::*;

    acq_req_t              a_req;
    acq_req_t              acq_data;
    logic                  acq_valid;
    logic                  acq_ready;
    rel_req_t              c_rel;
    logic                  c_rel_valid;
    logic                  c_rel_ready;
    rel_req_t              rel_data;
    logic                  rel_valid;
    logic                  rel_ready;
    logic [$clog2(SETS)-1:0] rd_set;
    dir_entry_t [WAYS-1:0] rd_entries;
    logic [$clog2(WAYS)-1:0] victim_way;
    logic                  we;
    logic [$clog2(SETS)-1:0] wr_set;
    logic [$clog2(WAYS)-1:0] wr_way;
    dir_entry_t            wr_entry;
    logic                  victim_advance;
    logic                  probe_start;
    logic [CORES-1:0]      probe_mask;
    logic [ADDR_W-1:0]     probe_addr;
    cap_t                  probe_cap;
    logic                  probe_done;

    assign a_req = '{opcode: a_opcode_i, grow: a_param_i, source: a_source_i,
                     address: a_address_i};

    req_fifo #(.payload_t(acq_req_t)) acq_fifo (
        .clk_i, .rst_ni,
        .push_valid_i(a_valid_i), .push_ready_o(a_ready_o), .push_data_i(a_req),
        .pop_valid_o(acq_valid), .pop_ready_i(acq_ready), .pop_data_o(acq_data)
    );

    req_fifo #(.payload_t(rel_req_t)) rel_fifo (
        .clk_i, .rst_ni,
        .push_valid_i(c_rel_valid), .push_ready_o(c_rel_ready), .push_data_i(c_rel),
        .pop_valid_o(rel_valid), .pop_ready_i(rel_ready), .pop_data_o(rel_data)
    );

    dir_store #(.CORES(CORES), .WAYS(WAYS), .SETS(SETS)) u_dir_store (
        .clk_i, .rst_ni,
        .rd_set_i(rd_set), .rd_entries_o(rd_entries), .victim_way_o(victim_way),
        .we_i(we), .wr_set_i(wr_set), .wr_way_i(wr_way), .wr_entry_i(wr_entry),
        .victim_advance_i(victim_advance)
    );

    coherence_ctrl #(.CORES(CORES), .WAYS(WAYS), .SETS(SETS)) u_ctrl (
        .clk_i, .rst_ni,
        .acq_valid_i(acq_valid), .acq_ready_o(acq_ready), .acq_data_i(acq_data),
        .rel_valid_i(rel_valid), .rel_ready_o(rel_ready), .rel_data_i(rel_data),
        .rd_set_o(rd_set), .rd_entries_i(rd_entries), .victim_way_i(victim_way),
        .we_o(we), .wr_set_o(wr_set), .wr_way_o(wr_way), .wr_entry_o(wr_entry),
        .victim_advance_o(victim_advance),
        .probe_start_o(probe_start), .probe_mask_o(probe_mask),
        .probe_addr_o(probe_addr), .probe_cap_o(probe_cap), .probe_done_i(probe_done),
        .d_valid_o, .d_ready_i, .d_opcode_o, .d_param_o, .d_source_o
    );

    probe_tracker #(.CORES(CORES)) u_probe_tracker (
        .clk_i, .rst_ni,
        .start_i(probe_start), .mask_i(probe_mask), .addr_i(probe_addr),
        .cap_i(probe_cap), .done_o(probe_done),
        .b_valid_o, .b_ready_i, .b_opcode_o, .b_param_o, .b_address_o, .b_dest_o,
        .c_valid_i, .c_ready_o, .c_opcode_i, .c_source_i, .c_address_i,
        .rel_valid_o(c_rel_valid), .rel_ready_i(c_rel_ready), .rel_data_o(c_rel)
    );

endmodule

// ==== tests/l2_dir_properties.sv ====
`timescale 1ns/1ns

module l2_dir_properties (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          b_valid_i,
    input  logic                          b_ready_i,
    input  tl_pkg::opcode_t               b_opcode_i,
    input  tl_pkg::cap_t                  b_param_i,
    input  logic [l2_dir_pkg::ADDR_W-1:0] b_address_i,
    input  logic [tl_pkg::CID_W-1:0]      b_dest_i,
    input  logic                          d_valid_i,
    input  logic                          d_ready_i,
    input  tl_pkg::opcode_t               d_opcode_i,
    input  tl_pkg::cap_t                  d_param_i,
    input  logic [tl_pkg::SOURCE_W-1:0]   d_source_i,
    input  logic                          probe_start_i,
    input  logic                          hit_i,
    input  logic [tl_pkg::CID_W-1:0]      req_core_i
);

    logic hit_round_q;   // Current probe round came from a hit
    int   fail_count = 0;   // Assertion failures so far

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_round_q <= 1'b0;
        end else if (probe_start_i) begin
            hit_round_q <= hit_i;
        end
    end

    b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_opcode_i) && $stable(b_param_i)
            && $stable(b_address_i) && $stable(b_dest_i))
        else begin
            $error("B channel changed before its handshake");
            fail_count++;
        end

    d_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_opcode_i) && $stable(d_param_i)
            && $stable(d_source_i))
        else begin
            $error("D channel changed before its handshake");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !b_valid_i && !d_valid_i)
        else begin
            $error("B or D valid high right after reset");
            fail_count++;
        end

    // Requester never probed in a hit round
    no_self_probe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_valid_i && hit_round_q |-> b_dest_i != req_core_i)
        else begin
            $error("Hit round probed the requesting core");
            fail_count++;
        end

endmodule

// ==== tests/tb_l2_dir.sv ====
`timescale 1ns/1ns

module tb_l2_dir;
    import tl_pkg::*;
    import l2_dir_pkg::*;

    localparam int MAX_PAT = 64;
    localparam int TIMEOUT = 400;   // Cycles per wait

    logic                clk_i;
    logic                rst_ni;
    logic                a_valid_i;
    logic                a_ready_o;
    opcode_t             a_opcode_i;
    grow_t               a_param_i;
    logic [SOURCE_W-1:0] a_source_i;
    logic [ADDR_W-1:0]   a_address_i;
    logic                b_valid_o;
    logic                b_ready_i;
    opcode_t             b_opcode_o;
    cap_t                b_param_o;
    logic [ADDR_W-1:0]   b_address_o;
    logic [CID_W-1:0]    b_dest_o;
    logic                c_valid_i;
    logic                c_ready_o;
    opcode_t             c_opcode_i;
    logic [SOURCE_W-1:0] c_source_i;
    logic [ADDR_W-1:0]   c_address_i;
    logic                d_valid_o;
    logic                d_ready_i;
    opcode_t             d_opcode_o;
    cap_t                d_param_o;
    logic [SOURCE_W-1:0] d_source_o;

    // Pattern table
    string             pat_kind [MAX_PAT];
    logic [CID_W-1:0]  pat_core [MAX_PAT];
    opcode_t           pat_op [MAX_PAT];
    grow_t             pat_grow [MAX_PAT];
    logic [ADDR_W-1:0] pat_addr [MAX_PAT];
    logic [3:0]        pat_mask [MAX_PAT];
    cap_t              pat_cap [MAX_PAT];
    logic [ADDR_W-1:0] pat_paddr [MAX_PAT];
    opcode_t           pat_dop [MAX_PAT];
    cap_t              pat_dparam [MAX_PAT];
    int                n_pat = 0;
    int                resp_idx = 0;    // Next expected D response
    int                err_count = 0;
    integer            seed = 32'h3cb9;
    logic [3:0]        seen_mask = '0;
    int                ack_core_q [$];
    int                ack_dly_q [$];

    l2_dir_top dut (.*);

    bind l2_dir_top l2_dir_properties props (
        .clk_i, .rst_ni,
        .b_valid_i(b_valid_o), .b_ready_i, .b_opcode_i(b_opcode_o), .b_param_i(b_param_o),
        .b_address_i(b_address_o), .b_dest_i(b_dest_o),
        .d_valid_i(d_valid_o), .d_ready_i, .d_opcode_i(d_opcode_o), .d_param_i(d_param_o),
        .d_source_i(d_source_o),
        .probe_start_i(u_ctrl.probe_start_o), .hit_i(u_ctrl.hit), .req_core_i(u_ctrl.req_core)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic stop_on_failure(input string why);
        err_count++;
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_acquire(input int idx);
        int waited;
        waited = 0;
        a_valid_i   = 1'b1;
        a_opcode_i  = pat_op[idx];
        a_param_i   = pat_grow[idx];
        a_source_i  = {pat_core[idx], 4'h0};
        a_address_i = pat_addr[idx];
        #2;
        while (!a_ready_o) begin
            if (waited == TIMEOUT) begin
                stop_on_failure("Acquire was never accepted on channel A");
            end
            waited++;
            @(posedge clk_i);
            #3;
        end
        @(posedge clk_i);
        #1;
        a_valid_i = 1'b0;
    endtask

    task automatic send_c(input opcode_t op, input logic [CID_W-1:0] core,
                          input logic [ADDR_W-1:0] addr);
        int waited;
        waited = 0;
        c_valid_i   = 1'b1;
        c_opcode_i  = op;
        c_source_i  = {core, 4'h0};
        c_address_i = addr;
        #2;
        while (!c_ready_o) begin
            if (waited == TIMEOUT) begin
                stop_on_failure("Message on channel C was never accepted");
            end
            waited++;
            @(posedge clk_i);
            #3;
        end
        @(posedge clk_i);
        #1;
        c_valid_i = 1'b0;
    endtask

    initial begin : main_seq
        int          fd;
        string       line;
        string       kind;
        int          core, op, grow, cap, dop, dpar, waited;
        logic [31:0] addr, paddr;
        logic [3:0]  mask;
        a_valid_i = 1'b0;
        a_opcode_i = '0;
        a_param_i = '0;
        a_source_i = '0;
        a_address_i = '0;
        c_valid_i = 1'b0;
        c_opcode_i = '0;
        c_source_i = '0;
        c_address_i = '0;
        rst_ni = 1'b0;
        fd = $fopen("tests/l2_dir_patterns.txt", "r");
        if (fd == 0) begin
            stop_on_failure("Could not open the pattern file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#" && $sscanf(line, "%s %d %d %d %h %h %d %h %d %d",
                    kind, core, op, grow, addr, mask, cap, paddr, dop, dpar) == 10) begin
                pat_kind[n_pat]   = kind;
                pat_core[n_pat]   = core[CID_W-1:0];
                pat_op[n_pat]     = op[2:0];
                pat_grow[n_pat]   = grow[2:0];
                pat_addr[n_pat]   = addr;
                pat_mask[n_pat]   = mask;
                pat_cap[n_pat]    = cap[1:0];
                pat_paddr[n_pat]  = paddr;
                pat_dop[n_pat]    = dop[2:0];
                pat_dparam[n_pat] = dpar[1:0];
                n_pat++;
            end
        end
        $fclose(fd);
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;
        compare_value("a_ready_o", a_ready_o, 1'b1);   // Empty queue after reset
        for (int k = 0; k < n_pat; k++) begin
            if (pat_kind[k] == "R") begin
                waited = 0;   // Release goes out once the earlier requests are answered
                while (resp_idx != k) begin
                    if (waited == TIMEOUT) begin
                        stop_on_failure("Responses before a Release never arrived");
                    end
                    waited++;
                    @(posedge clk_i);
                    #1;
                end
                send_c(RELEASE, pat_core[k], pat_addr[k]);
            end else begin
                send_acquire(k);
            end
        end
        waited = 0;
        while (resp_idx != n_pat) begin
            if (waited == TIMEOUT) begin
                stop_on_failure("Not every request got its D response");
            end
            waited++;
            @(posedge clk_i);
            #1;
        end
        repeat (2) @(posedge clk_i);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : ready_stalls
        b_ready_i = 1'b0;
        d_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            if (rst_ni) begin
                b_ready_i = ($random(seed) & 3) != 0;   // Stall about one cycle in four
                d_ready_i = ($random(seed) & 3) != 0;
            end
        end
    end

    // Samples just before each edge, where a transfer is decided
    initial begin : channel_monitor
        forever begin
            @(posedge clk_i);
            #3;
            if (dut.props.fail_count != 0) begin
                stop_on_failure("A bound protocol assertion failed");
            end
            if (rst_ni && b_valid_o && b_ready_i) begin
                if (resp_idx >= n_pat) begin
                    stop_on_failure("Probe seen with no request outstanding");
                end
                compare_value("b_opcode_o", b_opcode_o, PROBE_BLOCK);
                compare_value("b_param_o", b_param_o, pat_cap[resp_idx]);
                compare_value("b_address_o", b_address_o, pat_paddr[resp_idx]);
                seen_mask[b_dest_o] = 1'b1;
                ack_core_q.push_back(int'(b_dest_o));
                ack_dly_q.push_back($random(seed) & 3);
            end
            if (rst_ni && d_valid_o && d_ready_i) begin
                if (resp_idx >= n_pat) begin
                    stop_on_failure("D response seen with no request outstanding");
                end
                compare_value("probe_mask", seen_mask, pat_mask[resp_idx]);
                compare_value("d_opcode_o", d_opcode_o, pat_dop[resp_idx]);
                compare_value("d_param_o", d_param_o, pat_dparam[resp_idx]);
                compare_value("d_source_o", d_source_o, {pat_core[resp_idx], 4'h0});
                seen_mask = '0;
                resp_idx++;
            end
        end
    end

    initial begin : probe_responder
        int               dly;
        logic [CID_W-1:0] core;
        forever begin
            @(posedge clk_i);
            #1;
            if (ack_core_q.size() != 0) begin
                core = CID_W'(ack_core_q.pop_front());
                dly  = ack_dly_q.pop_front();
                if (dly > 0) begin
                    repeat (dly) @(posedge clk_i);
                    #1;
                end
                send_c(PROBE_ACK, core, '0);
            end
        end
    end

endmodule

// ==== tests/l2_dir_patterns.txt ====
# kind core a_opcode a_grow address | probe_mask probe_cap probe_address | d_opcode d_param
# kind A is an Acquire on channel A, R a dataless Release on C; numbers are hex where shown so
A 0 6 0 00001040 0 0 00000000 4 1
A 1 6 1 00002040 0 0 00000000 4 0
A 2 6 0 00002040 2 1 00002040 4 1
A 3 7 0 00002040 6 2 00002040 4 0
A 1 6 0 00002040 8 1 00002040 4 1
R 3 6 0 00002040 0 0 00000000 6 0
A 0 7 0 00002040 2 2 00002040 4 0
R 2 6 0 00007040 0 0 00000000 6 0
A 0 6 0 00001000 0 0 00000000 4 1
A 1 6 1 00002000 0 0 00000000 4 0
A 2 6 0 00003000 0 0 00000000 4 1
A 3 7 0 00004000 0 0 00000000 4 0
A 1 6 0 00005000 1 2 00001000 4 1
A 0 6 1 00006000 2 2 00002000 4 0
A 2 7 0 00007000 4 2 00003000 4 0
A 3 6 0 00005000 0 0 00000000 4 1
A 0 7 0 00005000 a 2 00005000 4 0

// ==== filelist.f ====
src/tl_pkg.sv
src/l2_dir_pkg.sv
src/req_fifo.sv
src/dir_store.sv
src/probe_tracker.sv
src/coherence_ctrl.sv
src/l2_dir_top.sv
tests/l2_dir_properties.sv
tests/tb_l2_dir.sv
